// ==== cop_pkg.sv ====
package cop_pkg;

    localparam int CR_IDX_W = 4;                     // 16 coprocessor registers

    localparam logic [6:0] COP_OPCODE = 7'b0001011;  // custom-0 major opcode

    // Instruction group, held in funct3
    localparam logic [2:0] F3_PACKED  = 3'b000;
    localparam logic [2:0] F3_BITWISE = 3'b001;
    localparam logic [2:0] F3_LD_LIU  = 3'b010;
    localparam logic [2:0] F3_LD_HIU  = 3'b011;
    localparam logic [2:0] F3_MOVE    = 3'b100;

    localparam logic [2:0] ICLASS_NONE         = 3'd0;  // Illegal instruction
    localparam logic [2:0] ICLASS_PACKED_ARITH = 3'd1;
    localparam logic [2:0] ICLASS_BITWISE      = 3'd2;
    localparam logic [2:0] ICLASS_MOVE         = 3'd3;

    // Packed arithmetic, also the op code in funct7[6:3]
    localparam logic [4:0] SCLASS_PADD    = 5'd0;
    localparam logic [4:0] SCLASS_PSUB    = 5'd1;
    localparam logic [4:0] SCLASS_PSLL_I  = 5'd2;
    localparam logic [4:0] SCLASS_PSRL_I  = 5'd3;
    // Bitwise
    localparam logic [4:0] SCLASS_BOP     = 5'd0;
    localparam logic [4:0] SCLASS_EXT     = 5'd1;
    localparam logic [4:0] SCLASS_INS     = 5'd2;
    localparam logic [4:0] SCLASS_LD_LIU  = 5'd3;
    localparam logic [4:0] SCLASS_LD_HIU  = 5'd4;
    // Move
    localparam logic [4:0] SCLASS_GPR2XCR = 5'd0;
    localparam logic [4:0] SCLASS_XCR2GPR = 5'd1;

    localparam logic [2:0] PW_32 = 3'd0;
    localparam logic [2:0] PW_16 = 3'd1;
    localparam logic [2:0] PW_8  = 3'd2;
    localparam logic [2:0] PW_4  = 3'd3;
    localparam logic [2:0] PW_2  = 3'd4;

    // One instruction word, seen as register fields or as immediate fields
    typedef union packed {
        struct packed {
            logic [6:0]          funct7;  // Op and pack width, or LUT, or move select
            logic [CR_IDX_W-1:0] crs2;
            logic                f20;
            logic [CR_IDX_W-1:0] crs1;
            logic                f15;     // Bitwise select, high bit
            logic [2:0]          funct3;
            logic [CR_IDX_W-1:0] crd;
            logic                f7;      // Bitwise select, low bit
            logic [6:0]          opcode;
        } r;
        struct packed {
            logic [10:0] imm11;   // imm8 sits in [10:3], shamt high bits in [3:0]
            logic        f20;     // Shift amount low bit
            logic [4:0]  imm5;
            logic [7:0]  ctl;     // Group, crd and select bits
            logic [6:0]  opcode;
        } i;
    } cop_instr_u;

endpackage

// ==== cop_dec_if.sv ====
`timescale 1ns/1ps

interface cop_dec_if;
    import cop_pkg::*;

    logic                exception;  // Illegal instruction
    logic [2:0]          iclass;
    logic [4:0]          subclass;
    logic [2:0]          pw;         // Pack width code
    logic [CR_IDX_W-1:0] crs1;
    logic [CR_IDX_W-1:0] crs2;       // Carries crd for ins and load-immediate
    logic [CR_IDX_W-1:0] crd;
    logic [4:0]          rd;         // GPR destination
    logic [31:0]         imm;

    modport decoder (
        output exception, iclass, subclass, pw,
        output crs1, crs2, crd, rd, imm
    );

    modport ctrl (
        input exception, iclass, subclass, pw,
        input crs1, crs2, crd, rd, imm
    );

    // Datapath units only need the operation and its constants
    modport unit (
        input subclass, pw, imm
    );

endinterface

// ==== cop_idecode.sv ====
`timescale 1ns/1ps

module cop_idecode #(
    parameter bit FEAT_PACKED  = 1'b1,
    parameter bit FEAT_BITWISE = 1'b1
) (
    input  cop_pkg::cop_instr_u instr_i,
    cop_dec_if.decoder          dec
);
    import cop_pkg::*;

    logic       op_ok;
    logic       dec_padd, dec_psub, dec_psll_i, dec_psrl_i;
    logic       dec_bop, dec_ext, dec_ins, dec_ld_liu, dec_ld_hiu;
    logic       dec_gpr2xcr, dec_xcr2gpr;
    logic       class_packed_arith, class_bitwise, class_move;
    logic       bad_pack_width;
    logic       feat_off;
    logic       crd_in_crs2;
    logic [1:0] bw_sel;
    logic [4:0] shamt;
    logic [7:0] imm8;
    logic [3:0] lut4;

    assign op_ok  = instr_i.i.opcode == COP_OPCODE;
    assign bw_sel = {instr_i.r.f15, instr_i.r.f7};

    // Packed arithmetic, op in funct7[6:3]
    assign dec_padd   = op_ok && instr_i.r.funct3 == F3_PACKED &&
                        instr_i.r.funct7[6:3] == SCLASS_PADD[3:0];
    assign dec_psub   = op_ok && instr_i.r.funct3 == F3_PACKED &&
                        instr_i.r.funct7[6:3] == SCLASS_PSUB[3:0];
    assign dec_psll_i = op_ok && instr_i.r.funct3 == F3_PACKED &&
                        instr_i.r.funct7[6:3] == SCLASS_PSLL_I[3:0];
    assign dec_psrl_i = op_ok && instr_i.r.funct3 == F3_PACKED &&
                        instr_i.r.funct7[6:3] == SCLASS_PSRL_I[3:0];

    assign dec_bop    = op_ok && instr_i.r.funct3 == F3_BITWISE && bw_sel == 2'b00;
    assign dec_ext    = op_ok && instr_i.r.funct3 == F3_BITWISE && bw_sel == 2'b01;
    assign dec_ins    = op_ok && instr_i.r.funct3 == F3_BITWISE && bw_sel == 2'b10;
    assign dec_ld_liu = op_ok && instr_i.r.funct3 == F3_LD_LIU;
    assign dec_ld_hiu = op_ok && instr_i.r.funct3 == F3_LD_HIU;

    assign dec_gpr2xcr = op_ok && instr_i.r.funct3 == F3_MOVE && instr_i.r.funct7 == 7'd0;
    assign dec_xcr2gpr = op_ok && instr_i.r.funct3 == F3_MOVE && instr_i.r.funct7 == 7'd1;

    assign class_packed_arith = dec_padd || dec_psub || dec_psll_i || dec_psrl_i;
    assign class_bitwise      = dec_bop || dec_ext || dec_ins || dec_ld_liu || dec_ld_hiu;
    assign class_move         = dec_gpr2xcr || dec_xcr2gpr;

    assign dec.pw = instr_i.r.funct7[2:0];

    // Codes 5 to 7 have no lane size
    assign bad_pack_width = class_packed_arith && dec.pw[2] && |dec.pw[1:0];
    assign feat_off       = (class_packed_arith && !FEAT_PACKED) ||
                            (class_bitwise && !FEAT_BITWISE);

    // Anything not matched, load/store included, lands here
    assign dec.exception = !(class_packed_arith || class_bitwise || class_move) ||
                           bad_pack_width || feat_off;

    assign dec.iclass = dec.exception ? ICLASS_NONE :
                        {3{class_packed_arith}} & ICLASS_PACKED_ARITH |
                        {3{class_bitwise}}      & ICLASS_BITWISE      |
                        {3{class_move}}         & ICLASS_MOVE;

    assign dec.subclass = {5{dec_padd}}    & SCLASS_PADD    |
                          {5{dec_psub}}    & SCLASS_PSUB    |
                          {5{dec_psll_i}}  & SCLASS_PSLL_I  |
                          {5{dec_psrl_i}}  & SCLASS_PSRL_I  |
                          {5{dec_bop}}     & SCLASS_BOP     |
                          {5{dec_ext}}     & SCLASS_EXT     |
                          {5{dec_ins}}     & SCLASS_INS     |
                          {5{dec_ld_liu}}  & SCLASS_LD_LIU  |
                          {5{dec_ld_hiu}}  & SCLASS_LD_HIU  |
                          {5{dec_gpr2xcr}} & SCLASS_GPR2XCR |
                          {5{dec_xcr2gpr}} & SCLASS_XCR2GPR;

    // Old crd value is needed, so it goes out on the second read port
    assign crd_in_crs2 = dec_ins || dec_ld_liu || dec_ld_hiu;

    assign dec.crs1 = instr_i.r.crs1;
    assign dec.crs2 = crd_in_crs2 ? instr_i.r.crd : instr_i.r.crs2;
    assign dec.crd  = instr_i.r.crd;
    assign dec.rd   = {instr_i.r.crd, instr_i.r.f7};  // Bits 11:7

    assign shamt = {instr_i.i.imm11[3:0], instr_i.i.f20};
    assign imm8  = instr_i.i.imm11[10:3];
    assign lut4  = instr_i.r.funct7[3:0];

    assign dec.imm = {32{dec_ld_liu || dec_ld_hiu}} &
                         {16'b0, instr_i.i.imm11, instr_i.i.imm5} |
                     {32{dec_ext || dec_ins}}       & {24'b0, imm8} |
                     {32{dec_psll_i || dec_psrl_i}} & {27'b0, shamt} |
                     {32{dec_bop}}                  & {28'b0, lut4};

endmodule

// ==== cop_regfile.sv ====
`timescale 1ns/1ps

module cop_regfile (
    input  logic                         g_clk,
    input  logic                         arst_n_i,
    input  logic [cop_pkg::CR_IDX_W-1:0] rs1_addr_i,
    input  logic [cop_pkg::CR_IDX_W-1:0] rs2_addr_i,
    output logic [31:0]                  rs1_data_o,
    output logic [31:0]                  rs2_data_o,
    input  logic                         wen_i,
    input  logic [cop_pkg::CR_IDX_W-1:0] waddr_i,
    input  logic [31:0]                  wdata_i
);
    import cop_pkg::*;

    localparam int NREGS = 2 ** CR_IDX_W;

    logic [31:0] regs [NREGS];

    // Architectural state starts at zero
    always_ff @(posedge g_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, a write lands before the next instruction reads
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// ==== cop_palu.sv ====
`timescale 1ns/1ps

module cop_palu (
    cop_dec_if.unit     dec,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    output logic [31:0] result_o
);
    import cop_pkg::*;

    logic [5:0]  lane_w;     // Lane width in bits
    logic [4:0]  lane_mask;  // Bit position inside a lane
    logic [4:0]  shamt;
    logic        sub;
    logic        left;
    logic [31:0] add_res;
    logic [31:0] sh_res;

    always_comb begin
        case (dec.pw)
            PW_32:   lane_w = 6'd32;
            PW_16:   lane_w = 6'd16;
            PW_8:    lane_w = 6'd8;
            PW_4:    lane_w = 6'd4;
            PW_2:    lane_w = 6'd2;
            default: lane_w = 6'd1;  // Illegal, raised by the decoder
        endcase
    end

    assign lane_mask = 5'(lane_w - 6'd1);
    assign shamt     = dec.imm[4:0];
    assign sub       = dec.subclass == SCLASS_PSUB;
    assign left      = dec.subclass == SCLASS_PSLL_I;

    // Ripple adder whose carry restarts at every lane boundary
    always_comb begin
        logic c;
        logic b2;
        c = sub;
        for (int b = 0; b < 32; b++) begin
            if ((5'(b) & lane_mask) == 5'd0) c = sub;  // Lane start
            b2         = rs2_i[b] ^ sub;
            add_res[b] = rs1_i[b] ^ b2 ^ c;
            c          = (rs1_i[b] & b2) | (c & (rs1_i[b] ^ b2));
        end
    end

    // Shift counts are lane-relative, so an over-width shift empties the lane
    always_comb begin
        logic [5:0] pos;
        sh_res = '0;
        for (int b = 0; b < 32; b++) begin
            pos = {1'b0, 5'(b) & lane_mask};
            if (left) begin
                if (pos >= {1'b0, shamt}) sh_res[b] = rs1_i[b - int'(shamt)];
            end else begin
                if (pos + {1'b0, shamt} < lane_w) sh_res[b] = rs1_i[b + int'(shamt)];
            end
        end
    end

    always_comb begin
        case (dec.subclass)
            SCLASS_PADD, SCLASS_PSUB:     result_o = add_res;
            SCLASS_PSLL_I, SCLASS_PSRL_I: result_o = sh_res;
            default:                      result_o = '0;
        endcase
    end

endmodule

// ==== cop_bitwise.sv ====
`timescale 1ns/1ps

module cop_bitwise (
    cop_dec_if.unit     dec,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    input  logic [31:0] rd_old_i,
    output logic [31:0] result_o
);
    import cop_pkg::*;

    logic [3:0]  lut;
    logic [5:0]  start_b;  // Field start in bits
    logic [5:0]  len_b;    // Field length in bits
    logic [31:0] fmask;
    logic [31:0] bop_res;

    assign lut     = dec.imm[3:0];
    assign start_b = {dec.imm[7:4], 2'b00};  // Nibbles to bits
    assign len_b   = {dec.imm[3:0], 2'b00};
    assign fmask   = (len_b >= 6'd32) ? '1 : ~(32'hFFFF_FFFF << len_b);

    // Table index is {rs1 bit, rs2 bit}
    always_comb begin
        for (int b = 0; b < 32; b++) begin
            bop_res[b] = lut[{rs1_i[b], rs2_i[b]}];
        end
    end

    always_comb begin
        case (dec.subclass)
            SCLASS_BOP:    result_o = bop_res;
            SCLASS_EXT:    result_o = (rs1_i >> start_b) & fmask;
            SCLASS_INS:    result_o = (rd_old_i & ~(fmask << start_b)) |
                                      ((rs1_i & fmask) << start_b);
            SCLASS_LD_LIU: result_o = {rd_old_i[31:16], dec.imm[15:0]};
            SCLASS_LD_HIU: result_o = {dec.imm[15:0], rd_old_i[15:0]};
            default:       result_o = '0;
        endcase
    end

endmodule

// ==== cop_ctrl.sv ====
`timescale 1ns/1ps

module cop_ctrl (
    input  logic                         g_clk,
    input  logic                         arst_n_i,
    input  logic                         instr_valid_i,
    cop_dec_if.ctrl                      dec,
    input  logic [31:0]                  gpr_rs1_i,
    input  logic [31:0]                  rs1_i,
    input  logic [31:0]                  palu_res_i,
    input  logic [31:0]                  bit_res_i,
    output logic                         cr_wen_o,
    output logic [cop_pkg::CR_IDX_W-1:0] cr_waddr_o,
    output logic [31:0]                  cr_wdata_o,
    output logic                         wb_valid_o,
    output logic [cop_pkg::CR_IDX_W-1:0] wb_crd_o,
    output logic [31:0]                  wb_data_o,
    output logic                         gpr_wen_o,
    output logic [4:0]                   gpr_rd_o,
    output logic [31:0]                  gpr_wdata_o,
    output logic                         exc_o
);
    import cop_pkg::*;

    logic to_gpr;  // xcr2gpr writes the core, not the register file
    logic gpr_we;

    assign to_gpr = dec.iclass == ICLASS_MOVE && dec.subclass == SCLASS_XCR2GPR;
    assign gpr_we = instr_valid_i && !dec.exception && to_gpr;

    assign cr_wen_o   = instr_valid_i && !dec.exception && !to_gpr;
    assign cr_waddr_o = dec.crd;

    always_comb begin
        case (dec.iclass)
            ICLASS_PACKED_ARITH: cr_wdata_o = palu_res_i;
            ICLASS_BITWISE:      cr_wdata_o = bit_res_i;
            default:             cr_wdata_o = gpr_rs1_i;  // gpr2xcr
        endcase
    end

    // One-cycle outcome pulses
    always_ff @(posedge g_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
            gpr_wen_o  <= 1'b0;
            exc_o      <= 1'b0;
        end else begin
            wb_valid_o <= cr_wen_o;
            gpr_wen_o  <= gpr_we;
            exc_o      <= instr_valid_i && dec.exception;
        end
    end

    always_ff @(posedge g_clk) begin
        wb_crd_o    <= cr_waddr_o;
        wb_data_o   <= cr_wdata_o;
        gpr_rd_o    <= dec.rd;
        gpr_wdata_o <= rs1_i;  // Value of crs1
    end

endmodule

// ==== cop_top.sv ====
`timescale 1ns/1ps

module cop_top #(
    parameter bit FEAT_PACKED  = 1'b1,
    parameter bit FEAT_BITWISE = 1'b1
) (
    input  logic        g_clk,
    input  logic        arst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] gpr_rs1_i,
    output logic        wb_valid_o,
    output logic [3:0]  wb_crd_o,
    output logic [31:0] wb_data_o,
    output logic        gpr_wen_o,
    output logic [4:0]  gpr_rd_o,
    output logic [31:0] gpr_wdata_o,
    output logic        exc_o
);
    import cop_pkg::*;

    logic [31:0]         rs1_data;
    logic [31:0]         rs2_data;  // crs2, or old crd for ins and load-immediate
    logic [31:0]         palu_res;
    logic [31:0]         bit_res;
    logic                cr_wen;
    logic [CR_IDX_W-1:0] cr_waddr;
    logic [31:0]         cr_wdata;

    cop_dec_if dec ();

    cop_idecode #(
        .FEAT_PACKED  (FEAT_PACKED),
        .FEAT_BITWISE (FEAT_BITWISE)
    ) u_idecode (
        .instr_i (instr_i),
        .dec     (dec.decoder)
    );

    cop_regfile u_regfile (
        .g_clk      (g_clk),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (dec.crs1),
        .rs2_addr_i (dec.crs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (cr_wen),
        .waddr_i    (cr_waddr),
        .wdata_i    (cr_wdata)
    );

    cop_palu u_palu (
        .dec      (dec.unit),
        .rs1_i    (rs1_data),
        .rs2_i    (rs2_data),
        .result_o (palu_res)
    );

    cop_bitwise u_bitwise (
        .dec      (dec.unit),
        .rs1_i    (rs1_data),
        .rs2_i    (rs2_data),
        .rd_old_i (rs2_data),
        .result_o (bit_res)
    );

    cop_ctrl u_ctrl (
        .g_clk         (g_clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .dec           (dec.ctrl),
        .gpr_rs1_i     (gpr_rs1_i),
        .rs1_i         (rs1_data),
        .palu_res_i    (palu_res),
        .bit_res_i     (bit_res),
        .cr_wen_o      (cr_wen),
        .cr_waddr_o    (cr_waddr),
        .cr_wdata_o    (cr_wdata),
        .wb_valid_o    (wb_valid_o),
        .wb_crd_o      (wb_crd_o),
        .wb_data_o     (wb_data_o),
        .gpr_wen_o     (gpr_wen_o),
        .gpr_rd_o      (gpr_rd_o),
        .gpr_wdata_o   (gpr_wdata_o),
        .exc_o         (exc_o)
    );

endmodule

// ==== tb_cop_asserts.sv ====
`timescale 1ns/1ps

module tb_cop_asserts (
    input logic g_clk,
    input logic arst_n_i,
    input logic instr_valid_i,
    input logic wb_valid_o,
    input logic gpr_wen_o,
    input logic exc_o
);

    // Only one outcome per instruction
    a_one_outcome: assert property (@(posedge g_clk) disable iff (!arst_n_i)
        $onehot0({wb_valid_o, gpr_wen_o, exc_o}))
        else $error("more than one outcome pulse in a cycle");

    a_after_strobe: assert property (@(posedge g_clk) disable iff (!arst_n_i)
        (wb_valid_o || gpr_wen_o || exc_o) |-> $past(instr_valid_i))
        else $error("outcome pulse without a strobe in the cycle before");

    a_quiet_in_reset: assert property (@(posedge g_clk)
        !arst_n_i |-> !(wb_valid_o || gpr_wen_o || exc_o))
        else $error("outcome pulse while in reset");

endmodule

bind cop_top tb_cop_asserts u_asserts (
    .g_clk         (g_clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_o    (wb_valid_o),
    .gpr_wen_o     (gpr_wen_o),
    .exc_o         (exc_o)
);

// ==== tb_cop.sv ====
`timescale 1ns/1ps

module tb_cop;

    localparam int NAME_W = 8 * 16;

    logic        g_clk;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] gpr_rs1_i;
    logic        wb_valid_o;
    logic [3:0]  wb_crd_o;
    logic [31:0] wb_data_o;
    logic        gpr_wen_o;
    logic [4:0]  gpr_rd_o;
    logic [31:0] gpr_wdata_o;
    logic        exc_o;

    // Test table read from cop_tests.txt
    logic [NAME_W-1:0] names[$];
    logic [31:0]       instrs[$];
    logic [31:0]       gpr_vals[$];
    logic [31:0]       kinds[$];
    int                exp_idx[$];
    logic [31:0]       exp_data[$];

    int errors = 0;
    int passed = 0;
    int cycles = 0;
    int cycle_limit = 0;

    cop_top #(
        .FEAT_PACKED  (1'b1),
        .FEAT_BITWISE (1'b1)
    ) UUT (
        .g_clk         (g_clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .gpr_rs1_i     (gpr_rs1_i),
        .wb_valid_o    (wb_valid_o),
        .wb_crd_o      (wb_crd_o),
        .wb_data_o     (wb_data_o),
        .gpr_wen_o     (gpr_wen_o),
        .gpr_rd_o      (gpr_rd_o),
        .gpr_wdata_o   (gpr_wdata_o),
        .exc_o         (exc_o)
    );

    initial g_clk = 1'b0;
    always #20 g_clk = ~g_clk;  // 40 ns period

    // Run limit set once the table length is known
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, tests did not complete", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_wb(input logic [NAME_W-1:0] name, input logic [3:0] idx,
                            input logic [31:0] data);
        if (!wb_valid_o) begin
            $display("%0s: no write-back seen", name);
            errors++;
        end else if (wb_crd_o !== idx || wb_data_o !== data) begin
            $display("FAILED %0s: expected c%0d=%h, actual c%0d=%h",
                     name, idx, data, wb_crd_o, wb_data_o);
            errors++;
        end else begin
            $display("ok %0s: c%0d=%h", name, wb_crd_o, wb_data_o);
            passed++;
        end
    endtask

    task automatic check_gpr(input logic [NAME_W-1:0] name, input logic [4:0] idx,
                             input logic [31:0] data);
        if (!gpr_wen_o) begin
            $display("%0s: no GPR write seen", name);
            errors++;
        end else if (gpr_rd_o !== idx || gpr_wdata_o !== data) begin
            $display("FAILED %0s: expected x%0d=%h, actual x%0d=%h",
                     name, idx, data, gpr_rd_o, gpr_wdata_o);
            errors++;
        end else begin
            $display("ok %0s: x%0d=%h", name, gpr_rd_o, gpr_wdata_o);
            passed++;
        end
    endtask

    task automatic check_exc(input logic [NAME_W-1:0] name);
        if (exc_o !== 1'b1) begin
            $display("%0s: no exception seen", name);
            errors++;
        end else begin
            $display("ok %0s: exception", name);
            passed++;
        end
    endtask

    task automatic check_result(input int i);
        if (kinds[i] == "wb") check_wb(names[i], 4'(exp_idx[i]), exp_data[i]);
        else if (kinds[i] == "gpr") check_gpr(names[i], 5'(exp_idx[i]), exp_data[i]);
        else if (kinds[i] == "exc") check_exc(names[i]);
        else begin
            $display("%0s: unknown result kind in the tests file", names[i]);
            errors++;
        end
    endtask

    initial begin
        int                fd;
        int                n;
        int                idx;
        logic [NAME_W-1:0] nm;
        logic [31:0]       kd;
        logic [31:0]       ins;
        logic [31:0]       gv;
        logic [31:0]       dv;
        string             line;

        instr_valid_i = 1'b0;
        instr_i       = '0;
        gpr_rs1_i     = '0;
        arst_n_i      = 1'b0;

        fd = $fopen("cop_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open cop_tests.txt");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%s %h %h %s %d %h", nm, ins, gv, kd, idx, dv) == 6) begin
                    names.push_back(nm);
                    instrs.push_back(ins);
                    gpr_vals.push_back(gv);
                    kinds.push_back(kd);
                    exp_idx.push_back(idx);
                    exp_data.push_back(dv);
                end else begin
                    $display("A line of cop_tests.txt does not hold six fields");
                    errors++;
                end
            end
            $fclose(fd);
            n = names.size();
            cycle_limit = 4 * n + 20;

            repeat (2) @(posedge g_clk);
            @(negedge g_clk);
            arst_n_i = 1'b1;

            // Strobe every cycle and check each result one cycle later
            for (int i = 0; i <= n; i++) begin
                @(negedge g_clk);
                if (i > 0) check_result(i - 1);
                if (i < n) begin
                    instr_valid_i = 1'b1;
                    instr_i       = instrs[i];
                    gpr_rs1_i     = gpr_vals[i];
                end else begin
                    instr_valid_i = 1'b0;
                    instr_i       = '0;
                    gpr_rs1_i     = '0;
                end
            end

            $display("%0d tests, %0d passed, %0d failed", n, passed, errors);
            if (errors == 0 && n > 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

// ==== cop_tests.txt ====
# name instr(hex) gpr_rs1(hex) kind(wb|gpr|exc) index(dec) data(hex)
# wb checks crd and written value, gpr checks rd and value, exc ignores index and data
mv_c1        0000410B 00FF00FF wb  1  00FF00FF
mv_c2        0000420B 00010001 wb  2  00010001
rd_c1        0201428B 00000000 gpr 5  00FF00FF
rd_c2        0202430B 00000000 gpr 6  00010001
padd_w8      0441030B 00000000 wb  3  00000000
padd_w32     0041040B 00000000 wb  4  01000100
padd_w16     0241050B 00000000 wb  5  01000100
psub_w2      1841060B 00000000 wb  6  00FE00FE
psub_w8      1422070B 00000000 wb  7  00020002
psub_w16     1222080B 00000000 wb  8  FF02FF02
psll_w8      2441090B 00000000 wb  9  00F000F0
psrl_w8_over 34810A0B 00000000 wb  10 00000000
psrl_w16     32410B0B 00000000 wb  11 000F000F
bop_xor      0C411C0B 00000000 wb  12 00FE00FE
ext_n1_l2    12011D8B 00000000 wb  13 0000000F
ins_n2_l2    22029D0B 00000000 wb  13 0000010F
ld_liu       BEE7AE0B 00000000 wb  14 0000BEEF
ld_hiu       CAEF3E0B 00000000 wb  14 CAFEBEEF
bad_opcode   0000410A DEADBEEF exc 0  00000000
bad_pw       0A41010B 00000000 exc 0  00000000
ldst_class   0000510B DEADBEEF exc 0  00000000
rd_c1_again  0201428B 00000000 gpr 5  00FF00FF
chain_ld     00004F0B 00000001 wb  15 00000001
chain_add1   01EF0F0B 00000000 wb  15 00000002
chain_add2   01EF0F0B 00000000 wb  15 00000004
chain_sll    203F0F0B 00000000 wb  15 00000020
rd_c14       020E408B 00000000 gpr 1  CAFEBEEF

// ==== all.f ====
cop_pkg.sv
cop_dec_if.sv
cop_idecode.sv
cop_regfile.sv
cop_palu.sv
cop_bitwise.sv
cop_ctrl.sv
cop_top.sv
tb_cop_asserts.sv
tb_cop.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cop
FILELIST  ?= all.f
PASS_MSG  := PASS: all tests

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST)) cop_tests.txt
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
